//--- flist.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_ctrl.sv
hw/dcache_store.sv
hw/dcache_word_select.sv
hw/dcache_line_merge.sv
hw/dcache_read_bus.sv
hw/dcache_write_bus.sv
hw/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

//--- hw/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Bus and line geometry
`define DC_ADDR_W          32
`define DC_WORD_W          32
`define DC_LINE_W          256
`define DC_WORDS_PER_LINE  8
`define DC_WORD_LSB        2     // Byte offset inside a word below this

`define DC_TAG_LSB         7
`define DC_TAG_W           8
`define DC_INDEX_LSB       5
`define DC_INDEX_W         2
`define DC_LINES           4

// Peripheral window, never cached
`define DC_UNCACHED_W      16
`define DC_UNCACHED_PREFIX 16'hffff

`endif

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl (
    input  wire                  cpu_clk,
    input  wire                  cpu_rst,
    input  dcache_pkg::byte_en_t data_ren,
    input  dcache_pkg::byte_en_t data_wen,
    input  dcache_pkg::addr_t    data_addr,
    input  wire                  dev_rrdy,
    input  wire                  dev_wrdy,
    input  wire                  dev_rvalid,
    input  wire                  hit,
    output logic                 data_valid,
    output logic                 data_wresp,
    output logic                 refill_we,
    output logic                 merge_we,
    output logic                 rd_issue,
    output logic                 wr_issue,
    output logic                 unc_sel
);

    dcache_pkg::rd_state_e rd_state, rd_next;
    dcache_pkg::wr_state_e wr_state, wr_next;
    logic unc_done_q;   // Uncached word captured last cycle
    logic wr_issued_q;  // cpu_wen is on the bus this cycle
    logic rd_hit;

    assign unc_sel = (data_addr[`DC_ADDR_W-1 -: `DC_UNCACHED_W] == `DC_UNCACHED_PREFIX);

    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            rd_state    <= dcache_pkg::RD_IDLE;
            wr_state    <= dcache_pkg::WR_IDLE;
            unc_done_q  <= 1'b0;
            wr_issued_q <= 1'b0;
        end else begin
            rd_state    <= rd_next;
            wr_state    <= wr_next;
            unc_done_q  <= (rd_state == dcache_pkg::RD_UNC_WAIT) && dev_rvalid;
            wr_issued_q <= wr_issue;
        end
    end

    // Read side
    always_comb begin
        rd_next   = rd_state;
        rd_issue  = 1'b0;
        refill_we = 1'b0;
        rd_hit    = 1'b0;
        case (rd_state)
            dcache_pkg::RD_IDLE: begin
                // Skip the cycle that still answers an uncached read
                if (|data_ren && !unc_done_q) rd_next = dcache_pkg::RD_TAG_CHK;
            end
            dcache_pkg::RD_TAG_CHK: begin
                if (unc_sel) begin
                    if (dev_rrdy) begin
                        rd_issue = 1'b1;
                        rd_next  = dcache_pkg::RD_UNC_WAIT;
                    end
                end else if (hit) begin
                    rd_hit  = 1'b1;
                    rd_next = dcache_pkg::RD_IDLE;
                end else if (dev_rrdy) begin
                    rd_issue = 1'b1;   // Line fill request
                    rd_next  = dcache_pkg::RD_REFILL;
                end
            end
            dcache_pkg::RD_REFILL: begin
                if (dev_rvalid) begin
                    refill_we = 1'b1;
                    rd_next   = dcache_pkg::RD_TAG_CHK;   // Hits on the fresh line
                end
            end
            dcache_pkg::RD_UNC_WAIT: begin
                if (dev_rvalid) rd_next = dcache_pkg::RD_IDLE;
            end
            default: rd_next = dcache_pkg::RD_IDLE;
        endcase
    end

    assign data_valid = rd_hit | unc_done_q;

    // Write-through side with no allocate on a miss
    always_comb begin
        wr_next    = wr_state;
        wr_issue   = 1'b0;
        merge_we   = 1'b0;
        data_wresp = 1'b0;
        case (wr_state)
            dcache_pkg::WR_IDLE: begin
                if (|data_wen) wr_next = dcache_pkg::WR_ISSUE;
            end
            dcache_pkg::WR_ISSUE: begin
                if (dev_wrdy) begin
                    wr_issue = 1'b1;
                    merge_we = hit && !unc_sel;
                    wr_next  = dcache_pkg::WR_WAIT;
                end
            end
            dcache_pkg::WR_WAIT: begin
                // Ready still high in the pulse cycle, so ignore it there
                if (dev_wrdy && !wr_issued_q) begin
                    data_wresp = 1'b1;
                    wr_next    = dcache_pkg::WR_IDLE;
                end
            end
            default: wr_next = dcache_pkg::WR_IDLE;
        endcase
    end

    a_one_response: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        !(data_valid && data_wresp))
        else $error("data_valid and data_wresp high together");

endmodule

`default_nettype wire

//--- hw/dcache_line_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_line_merge (
    input  dcache_pkg::line_t    line_q,
    input  dcache_pkg::addr_t    data_addr,
    input  dcache_pkg::byte_en_t data_wen,
    input  dcache_pkg::word_t    data_wdata,
    output dcache_pkg::line_t    merged_line
);

    dcache_pkg::word_sel_t word_sel;

    assign word_sel = data_addr[`DC_INDEX_LSB-1:`DC_WORD_LSB];

    // Untouched bytes keep their old value
    always_comb begin
        merged_line = line_q;
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            if (data_wen[b]) begin
                merged_line[word_sel*`DC_WORD_W + b*8 +: 8] = data_wdata[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]                 addr_t;
    typedef logic [`DC_WORD_W-1:0]                 word_t;
    typedef logic [`DC_LINE_W-1:0]                 line_t;
    typedef logic [`DC_TAG_W-1:0]                  tag_t;
    typedef logic [`DC_INDEX_W-1:0]                index_t;
    typedef logic [$clog2(`DC_WORDS_PER_LINE)-1:0] word_sel_t;
    typedef logic [`DC_WORD_W/8-1:0]               byte_en_t;

    typedef enum logic [1:0] {RD_IDLE, RD_TAG_CHK, RD_REFILL, RD_UNC_WAIT} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_ISSUE, WR_WAIT} wr_state_e;

    // One mask byte per enable bit
    function automatic word_t expand_be(input byte_en_t be);
        word_t mask;
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            mask[b*8 +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

//--- hw/dcache_read_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_read_bus (
    input  wire                  cpu_clk,
    input  wire                  cpu_rst,
    input  wire                  rd_issue,
    input  wire                  unc_sel,
    input  dcache_pkg::addr_t    data_addr,
    input  dcache_pkg::byte_en_t data_ren,
    input  wire                  dev_rvalid,
    input  dcache_pkg::line_t    dev_rdata,
    output dcache_pkg::byte_en_t cpu_ren,
    output dcache_pkg::addr_t    cpu_raddr,
    output dcache_pkg::word_t    unc_rdata
);

    dcache_pkg::addr_t line_addr;

    assign line_addr = {data_addr[`DC_ADDR_W-1:`DC_INDEX_LSB], {`DC_INDEX_LSB{1'b0}}};

    // Request strobe, one cycle per issue
    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            cpu_ren <= '0;
        end else if (rd_issue) begin
            cpu_ren <= unc_sel ? data_ren : '1;   // Whole line on a fill
        end else begin
            cpu_ren <= '0;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (rd_issue) cpu_raddr <= unc_sel ? data_addr : line_addr;
    end

    // Uncached word arrives in bits 31:0
    always_ff @(posedge cpu_clk) begin
        if (dev_rvalid && unc_sel) begin
            unc_rdata <= dev_rdata[`DC_WORD_W-1:0] & dcache_pkg::expand_be(data_ren);
        end
    end

endmodule

`default_nettype wire

//--- hw/dcache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_store (
    input  wire                cpu_clk,
    input  wire                cpu_rst,
    input  dcache_pkg::addr_t  data_addr,
    input  wire                refill_we,
    input  wire                merge_we,
    input  dcache_pkg::line_t  dev_rdata,
    input  dcache_pkg::line_t  merged_line,
    output dcache_pkg::line_t  line_q,
    output logic               hit
);

    dcache_pkg::index_t idx;
    dcache_pkg::tag_t   cur_tag;
    logic [`DC_LINES-1:0] valid_r;
    dcache_pkg::tag_t   tag_mem  [`DC_LINES];
    dcache_pkg::line_t  data_mem [`DC_LINES];
    logic               valid_q;
    dcache_pkg::tag_t   tag_q;

    assign idx     = data_addr[`DC_INDEX_LSB +: `DC_INDEX_W];
    assign cur_tag = data_addr[`DC_TAG_LSB +: `DC_TAG_W];

    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            valid_r <= '0;
            valid_q <= 1'b0;
        end else begin
            if (refill_we) valid_r[idx] <= 1'b1;
            valid_q <= refill_we | valid_r[idx];
        end
    end

    // Arrays plus the registered entry, new data forwarded on a write
    always_ff @(posedge cpu_clk) begin
        if (refill_we) begin
            tag_mem[idx]  <= cur_tag;
            data_mem[idx] <= dev_rdata;
        end else if (merge_we) begin
            data_mem[idx] <= merged_line;   // Tag already matches on a write hit
        end
        tag_q <= refill_we ? cur_tag : tag_mem[idx];
        if (refill_we) line_q <= dev_rdata;
        else if (merge_we) line_q <= merged_line;
        else line_q <= data_mem[idx];
    end

    assign hit = valid_q && (tag_q == cur_tag);

    a_single_writer: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        !(refill_we && merge_we))
        else $error("refill and merge write in the same cycle");

endmodule

`default_nettype wire

//--- hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                  cpu_clk,
    input  wire                  cpu_rst,
    // CPU load/store port
    input  dcache_pkg::byte_en_t data_ren,
    input  dcache_pkg::addr_t    data_addr,
    output logic                 data_valid,
    output dcache_pkg::word_t    data_rdata,
    input  dcache_pkg::byte_en_t data_wen,
    input  dcache_pkg::word_t    data_wdata,
    output logic                 data_wresp,
    // Write channel
    input  wire                  dev_wrdy,
    output dcache_pkg::byte_en_t cpu_wen,
    output dcache_pkg::addr_t    cpu_waddr,
    output dcache_pkg::word_t    cpu_wdata,
    // Read channel
    input  wire                  dev_rrdy,
    output dcache_pkg::byte_en_t cpu_ren,
    output dcache_pkg::addr_t    cpu_raddr,
    input  wire                  dev_rvalid,
    input  dcache_pkg::line_t    dev_rdata
);

    logic              hit;
    logic              refill_we;
    logic              merge_we;
    logic              rd_issue;
    logic              wr_issue;
    logic              unc_sel;
    dcache_pkg::line_t line_q;
    dcache_pkg::line_t merged_line;
    dcache_pkg::word_t word_rdata;
    dcache_pkg::word_t unc_rdata;

    dcache_ctrl u_ctrl (
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .data_ren   (data_ren),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .dev_rrdy   (dev_rrdy),
        .dev_wrdy   (dev_wrdy),
        .dev_rvalid (dev_rvalid),
        .hit        (hit),
        .data_valid (data_valid),
        .data_wresp (data_wresp),
        .refill_we  (refill_we),
        .merge_we   (merge_we),
        .rd_issue   (rd_issue),
        .wr_issue   (wr_issue),
        .unc_sel    (unc_sel)
    );

    dcache_store u_store (
        .cpu_clk     (cpu_clk),
        .cpu_rst     (cpu_rst),
        .data_addr   (data_addr),
        .refill_we   (refill_we),
        .merge_we    (merge_we),
        .dev_rdata   (dev_rdata),
        .merged_line (merged_line),
        .line_q      (line_q),
        .hit         (hit)
    );

    dcache_word_select u_word_select (
        .line_q     (line_q),
        .data_addr  (data_addr),
        .data_ren   (data_ren),
        .word_rdata (word_rdata)
    );

    dcache_line_merge u_line_merge (
        .line_q      (line_q),
        .data_addr   (data_addr),
        .data_wen    (data_wen),
        .data_wdata  (data_wdata),
        .merged_line (merged_line)
    );

    dcache_read_bus u_read_bus (
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .rd_issue   (rd_issue),
        .unc_sel    (unc_sel),
        .data_addr  (data_addr),
        .data_ren   (data_ren),
        .dev_rvalid (dev_rvalid),
        .dev_rdata  (dev_rdata),
        .cpu_ren    (cpu_ren),
        .cpu_raddr  (cpu_raddr),
        .unc_rdata  (unc_rdata)
    );

    dcache_write_bus u_write_bus (
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .wr_issue   (wr_issue),
        .data_addr  (data_addr),
        .data_wen   (data_wen),
        .data_wdata (data_wdata),
        .cpu_wen    (cpu_wen),
        .cpu_waddr  (cpu_waddr),
        .cpu_wdata  (cpu_wdata)
    );

    assign data_rdata = unc_sel ? unc_rdata : word_rdata;   // Peripheral reads bypass the line

endmodule

`default_nettype wire

//--- hw/dcache_word_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_word_select (
    input  dcache_pkg::line_t    line_q,
    input  dcache_pkg::addr_t    data_addr,
    input  dcache_pkg::byte_en_t data_ren,
    output dcache_pkg::word_t    word_rdata
);

    dcache_pkg::word_sel_t word_sel;
    dcache_pkg::word_t     word_raw;

    assign word_sel = data_addr[`DC_INDEX_LSB-1:`DC_WORD_LSB];

    // Word 0 sits in the low bits of the line
    assign word_raw = line_q[word_sel*`DC_WORD_W +: `DC_WORD_W];

    assign word_rdata = word_raw & dcache_pkg::expand_be(data_ren);   // Unread bytes are zero

endmodule

`default_nettype wire

//--- hw/dcache_write_bus.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_write_bus (
    input  wire                  cpu_clk,
    input  wire                  cpu_rst,
    input  wire                  wr_issue,
    input  dcache_pkg::addr_t    data_addr,
    input  dcache_pkg::byte_en_t data_wen,
    input  dcache_pkg::word_t    data_wdata,
    output dcache_pkg::byte_en_t cpu_wen,
    output dcache_pkg::addr_t    cpu_waddr,
    output dcache_pkg::word_t    cpu_wdata
);

    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            cpu_wen <= '0;
        end else begin
            cpu_wen <= wr_issue ? data_wen : '0;
        end
    end

    // Full address, disabled bytes forced to zero
    always_ff @(posedge cpu_clk) begin
        if (wr_issue) begin
            cpu_waddr <= data_addr;
            cpu_wdata <= data_wdata & dcache_pkg::expand_be(data_wen);
        end
    end

    a_wen_pulse: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        (cpu_wen != '0) |=> (cpu_wen == '0))
        else $error("cpu_wen held for two cycles");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_dcache \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_dcache > sim.log 2>&1

grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int MAX_CYCLES = 20000;
    localparam int ANY = 0;
    localparam int HIT = 1;
    localparam int BUS = 2;

    logic         cpu_clk;
    logic         cpu_rst;
    logic [3:0]   data_ren;
    logic [31:0]  data_addr;
    logic         data_valid;
    logic [31:0]  data_rdata;
    logic [3:0]   data_wen;
    logic [31:0]  data_wdata;
    logic         data_wresp;
    logic         dev_wrdy;
    logic [3:0]   cpu_wen;
    logic [31:0]  cpu_waddr;
    logic [31:0]  cpu_wdata;
    logic         dev_rrdy;
    logic [3:0]   cpu_ren;
    logic [31:0]  cpu_raddr;
    logic         dev_rvalid;
    logic [255:0] dev_rdata;
    logic [31:0]  peek_word;
    int           rd_count;
    int           wr_count;
    int           rd_base;
    int           wr_base;
    int           cycle_count;
    logic         expect_hit;
    logic         expect_bus;
    logic         rd_start;
    logic         valid_seen;
    logic         wresp_seen;

    dcache_top uut (
        .cpu_clk(cpu_clk), .cpu_rst(cpu_rst),
        .data_ren(data_ren), .data_addr(data_addr), .data_valid(data_valid),
        .data_rdata(data_rdata), .data_wen(data_wen), .data_wdata(data_wdata),
        .data_wresp(data_wresp), .dev_wrdy(dev_wrdy), .cpu_wen(cpu_wen),
        .cpu_waddr(cpu_waddr), .cpu_wdata(cpu_wdata), .dev_rrdy(dev_rrdy),
        .cpu_ren(cpu_ren), .cpu_raddr(cpu_raddr), .dev_rvalid(dev_rvalid),
        .dev_rdata(dev_rdata)
    );

    tb_mem_model mem_model (
        .cpu_clk(cpu_clk), .cpu_rst(cpu_rst),
        .cpu_ren(cpu_ren), .cpu_raddr(cpu_raddr),
        .cpu_wen(cpu_wen), .cpu_waddr(cpu_waddr), .cpu_wdata(cpu_wdata),
        .dev_rrdy(dev_rrdy), .dev_rvalid(dev_rvalid), .dev_rdata(dev_rdata),
        .dev_wrdy(dev_wrdy), .peek_addr(data_addr), .peek_word(peek_word),
        .rd_count(rd_count), .wr_count(wr_count)
    );

    always #2 cpu_clk = ~cpu_clk;

    function automatic logic [31:0] byte_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    // Responses taken at the clock edge and read back on the falling edge
    always @(posedge cpu_clk) begin
        valid_seen <= data_valid;
        wresp_seen <= data_wresp;
    end

    always @(posedge cpu_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: no response after %0d cycles", cycle_count);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    a_reset_quiet: assert property (@(posedge cpu_clk)
        cpu_rst |-> !data_valid && !data_wresp && cpu_ren == 4'h0 && cpu_wen == 4'h0)
        else report_failure("control outputs active during reset");
    a_rdata: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        data_valid |-> data_rdata == (peek_word & byte_mask(data_ren)))
        else report_failure("read data differs from memory model");
    a_hit_no_bus: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        expect_hit |-> cpu_ren == 4'h0)
        else report_failure("bus read issued on an expected hit");
    a_hit_latency: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        rd_start && expect_hit |=> data_valid)
        else report_failure("hit data not returned one cycle after request");
    a_bus_read_once: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        data_valid && expect_bus |-> rd_count == rd_base + 1)
        else report_failure("expected exactly one bus read");
    a_line_req: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        cpu_ren != 4'h0 && cpu_raddr[31:16] != 16'hffff
        |-> cpu_ren == 4'hf && cpu_raddr == {data_addr[31:5], 5'b0})
        else report_failure("line fill request malformed");
    a_unc_req: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        cpu_ren != 4'h0 && cpu_raddr[31:16] == 16'hffff
        |-> cpu_ren == data_ren && cpu_raddr == data_addr)
        else report_failure("uncached read request malformed");
    a_write_req: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        cpu_wen != 4'h0 |-> cpu_wen == data_wen && cpu_waddr == data_addr
        && cpu_wdata == (data_wdata & byte_mask(data_wen)))
        else report_failure("write request malformed");
    a_write_once: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        data_wresp |-> wr_count == wr_base + 1)
        else report_failure("expected exactly one bus write");
    a_ren_ready: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        cpu_ren != 4'h0 |-> $past(dev_rrdy))
        else report_failure("read pulse without read ready");
    a_wen_ready: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        cpu_wen != 4'h0 |-> $past(dev_wrdy))
        else report_failure("write pulse without write ready");

    task automatic load_word(input logic [31:0] addr, input logic [3:0] ren, input int mode);
        @(negedge cpu_clk);
        data_addr  = addr;
        data_ren   = ren;
        expect_hit = (mode == HIT);
        expect_bus = (mode == BUS);
        rd_base    = rd_count;
        rd_start   = 1'b1;
        @(negedge cpu_clk);
        rd_start = 1'b0;
        while (!valid_seen) @(negedge cpu_clk);
        data_ren   = 4'h0;
        expect_hit = 1'b0;
        expect_bus = 1'b0;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [3:0] wen,
                              input logic [31:0] wdata);
        @(negedge cpu_clk);
        data_addr  = addr;
        data_wen   = wen;
        data_wdata = wdata;
        wr_base    = wr_count;
        @(negedge cpu_clk);
        while (!wresp_seen) @(negedge cpu_clk);
        data_wen = 4'h0;
    endtask

    initial begin
        logic [31:0] addr;
        void'($urandom(35795));
        cpu_clk = 1'b0;
        cpu_rst = 1'b1;
        data_ren = 4'h0;
        data_addr = '0;
        data_wen = 4'h0;
        data_wdata = '0;
        expect_hit = 1'b0;
        expect_bus = 1'b0;
        rd_start = 1'b0;
        rd_base = 0;
        wr_base = 0;
        cycle_count = 0;
        repeat (4) @(posedge cpu_clk);
        @(negedge cpu_clk);
        cpu_rst = 1'b0;

        load_word(32'h0000_0104, 4'hf, BUS);      // Cold miss
        load_word(32'h0000_0104, 4'hf, HIT);
        load_word(32'h0000_0108, 4'b0110, HIT);
        load_word(32'h0000_0904, 4'hf, BUS);      // Same index, other tag
        load_word(32'h0000_0104, 4'hf, BUS);
        store_word(32'h0000_0104, 4'b0101, 32'hdead_beef);   // Write hit
        load_word(32'h0000_0104, 4'hf, HIT);
        store_word(32'h0000_0a40, 4'b0011, 32'h1234_5678);   // No allocate
        load_word(32'h0000_0a40, 4'hf, BUS);
        store_word(32'hffff_0008, 4'b1100, 32'hcafe_f00d);
        load_word(32'hffff_0008, 4'hf, BUS);
        load_word(32'hffff_0008, 4'b0011, BUS);

        // Small address window so hits and evictions both occur
        for (int i = 0; i < 400; i++) begin
            if ($urandom % 4 == 0) addr = {16'hffff, 11'h0, 5'($urandom) & 5'h1c};
            else addr = ($urandom % 512) & 32'h0000_01fc;
            if ($urandom % 3 == 0) begin
                store_word(addr, 4'(($urandom % 15) + 1), $urandom);
            end else begin
                load_word(addr, 4'(($urandom % 15) + 1), ANY);
            end
        end

        repeat (4) @(negedge cpu_clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire          cpu_clk,
    input  wire          cpu_rst,
    input  wire  [3:0]   cpu_ren,
    input  wire  [31:0]  cpu_raddr,
    input  wire  [3:0]   cpu_wen,
    input  wire  [31:0]  cpu_waddr,
    input  wire  [31:0]  cpu_wdata,
    output logic         dev_rrdy,
    output logic         dev_rvalid,
    output logic [255:0] dev_rdata,
    output logic         dev_wrdy,
    input  wire  [31:0]  peek_addr,
    output logic [31:0]  peek_word,
    output int           rd_count,
    output int           wr_count
);

    logic [31:0] mem      [8192];   // 32 KB cacheable space
    logic [31:0] unc_regs [8];      // Peripheral registers
    logic [31:0] req_addr;
    logic        rd_busy;
    int          rd_delay;
    int          wr_delay;

    function automatic logic in_uncached(input logic [31:0] a);
        return a[31:16] == 16'hffff;
    endfunction

    function automatic logic [255:0] line_data(input logic [31:0] a);
        logic [255:0] l;
        l = '0;
        if (in_uncached(a)) begin
            l[31:0] = unc_regs[a[4:2]];
        end else begin
            for (int w = 0; w < 8; w++) begin
                l[w*32 +: 32] = mem[{a[14:5], w[2:0]}];   // Word 0 in the low bits
            end
        end
        return l;
    endfunction

    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = (i * 32'h0001_0003) ^ 32'ha5c3_0000 ^ (i << 19);
        end
        for (int i = 0; i < 8; i++) begin
            unc_regs[i] = 32'h5a00_0000 | (i * 32'h0011_0101);
        end
        dev_rrdy   = 1'b0;
        dev_rvalid = 1'b0;
        dev_rdata  = '0;
        dev_wrdy   = 1'b0;
        rd_busy    = 1'b0;
        rd_delay   = 0;
        wr_delay   = 0;
        rd_count   = 0;
        wr_count   = 0;
    end

    assign peek_word = in_uncached(peek_addr) ? unc_regs[peek_addr[4:2]] : mem[peek_addr[14:2]];

    // Read channel, one request outstanding
    always @(negedge cpu_clk) begin
        dev_rvalid <= 1'b0;
        if (cpu_rst) begin
            dev_rrdy <= 1'b0;
            rd_busy  <= 1'b0;
        end else if (cpu_ren != 4'h0) begin
            rd_count <= rd_count + 1;
            req_addr <= cpu_raddr;
            rd_busy  <= 1'b1;
            rd_delay <= $urandom % 4;
            dev_rrdy <= 1'b0;
        end else if (rd_busy) begin
            if (rd_delay == 0) begin
                dev_rvalid <= 1'b1;
                dev_rdata  <= line_data(req_addr);
                rd_busy    <= 1'b0;
            end else begin
                rd_delay <= rd_delay - 1;
            end
        end else begin
            dev_rrdy <= ($urandom % 4) != 0;
        end
    end

    // Write channel, busy for 1 to 3 cycles after each pulse
    always @(negedge cpu_clk) begin
        if (cpu_rst) begin
            dev_wrdy <= 1'b0;
        end else if (cpu_wen != 4'h0) begin
            wr_count <= wr_count + 1;
            for (int b = 0; b < 4; b++) begin
                if (cpu_wen[b] && in_uncached(cpu_waddr)) begin
                    unc_regs[cpu_waddr[4:2]][b*8 +: 8] <= cpu_wdata[b*8 +: 8];
                end else if (cpu_wen[b]) begin
                    mem[cpu_waddr[14:2]][b*8 +: 8] <= cpu_wdata[b*8 +: 8];
                end
            end
            wr_delay <= ($urandom % 3) + 1;
            dev_wrdy <= 1'b0;
        end else if (wr_delay > 0) begin
            wr_delay <= wr_delay - 1;
            dev_wrdy <= (wr_delay == 1);   // Ready again means done
        end else begin
            dev_wrdy <= ($urandom % 4) != 0;
        end
    end

endmodule

`default_nettype wire
